// File: common/memPkg.sv
/*
 * Memory-side definitions for the instruction fetch subsystem.
 * Fetch address, instruction, block and load-port widths, plus the
 * fixed read latency of the instruction memory.
 */
`default_nettype none

package memPkg;

    // 4 KiB byte-addressed instruction space
    localparam int ADDR_BITS       = 12;
    localparam int WORD_BITS       = 32;
    localparam int BLOCK_WORDS     = 4;
    localparam int BLOCK_BITS      = WORD_BITS * BLOCK_WORDS;
    // address without the four offset bits
    localparam int BLOCK_ADDR_BITS = ADDR_BITS - 4;

    // cycles from memReq to memValid
    localparam int MEM_LATENCY     = 4;

    typedef logic [ADDR_BITS-1:0]       addrT;
    typedef logic [WORD_BITS-1:0]       wordT;
    // word 0 sits in the low bits
    typedef logic [BLOCK_BITS-1:0]      blockT;
    typedef logic [BLOCK_ADDR_BITS-1:0] blockAddrT;
    typedef logic [ADDR_BITS-3:0]       wordAddrT;

    // latency countdown in the memory
    typedef logic [$clog2(MEM_LATENCY+1)-1:0] latCntT;

endpackage

`default_nettype wire

// File: common/icachePkg.sv
/*
 * Instruction cache geometry.
 * Associativity, set count and the field widths that split a block
 * address into tag and index and a fetch address into word offset.
 */
`default_nettype none

package icachePkg;

    // 4-way, 8 sets of 16-byte blocks
    localparam int WAYS        = 4;
    localparam int SETS        = 8;

    // block address is {tag, index}
    localparam int INDEX_BITS  = 3;
    localparam int TAG_BITS    = 5;

    // word within a block
    localparam int OFFSET_BITS = 2;

    typedef logic [INDEX_BITS-1:0]  indexT;
    typedef logic [TAG_BITS-1:0]    tagT;

    // one bit per way, used for valid, MRU, hit and victim masks
    typedef logic [WAYS-1:0]        wayMaskT;

    typedef logic [OFFSET_BITS-1:0] offsetT;

    /*
     * Fetch address layout, top to bottom:
     *   tag (5) | index (3) | word offset (2) | byte (2)
     */

endpackage

`default_nettype wire

// File: icache/icacheArray.sv
/*
 * Instruction cache storage.
 * Holds valid bits, tags, data blocks and one MRU status bit per way.
 * Lookup and victim choice are combinational, fills and MRU updates
 * happen on the clock edge.
 */
`timescale 1ns/1ps
`default_nettype none

module icacheArray (
    input  logic              clk,
    input  logic              rst,
    input  logic              ren,
    input  logic              memWen,
    input  memPkg::blockAddrT blockAddr,
    input  memPkg::blockT     dataIn,
    output logic              hit,
    output memPkg::blockT     dataOut
);

    // per-set control columns
    icachePkg::wayMaskT validBits  [icachePkg::SETS];
    icachePkg::wayMaskT statusBits [icachePkg::SETS];

    // payload columns
    icachePkg::tagT     tagMem  [icachePkg::SETS][icachePkg::WAYS];
    memPkg::blockT      dataMem [icachePkg::SETS][icachePkg::WAYS];

    icachePkg::indexT   index;
    icachePkg::tagT     tag;
    icachePkg::wayMaskT hitWays;
    icachePkg::wayMaskT victimWays;
    icachePkg::wayMaskT touchWays;
    icachePkg::wayMaskT statusNext;

    // isolate the lowest set bit of a mask
    function automatic icachePkg::wayMaskT lowestOne(input icachePkg::wayMaskT m);
        return m & (~m + icachePkg::wayMaskT'(1));
    endfunction

    assign index = blockAddr[icachePkg::INDEX_BITS-1:0];
    assign tag   = blockAddr[icachePkg::INDEX_BITS +: icachePkg::TAG_BITS];

    // compare all ways of the set at once
    always_comb begin
        hitWays = '0;
        dataOut = '0;
        for (int w = 0; w < icachePkg::WAYS; w++) begin
            if (validBits[index][w] && (tagMem[index][w] == tag)) begin
                hitWays[w] = 1'b1;
                dataOut    = dataMem[index][w];
            end
        end
    end

    assign hit = |hitWays;

    /*
     * Victim: lowest invalid way while the set has room, otherwise the
     * lowest way whose MRU bit is clear. The update rule below never
     * leaves all MRU bits set, so a clear bit always exists.
     */
    always_comb begin
        if (&validBits[index]) begin
            victimWays = lowestOne(~statusBits[index]);
        end else begin
            victimWays = lowestOne(~validBits[index]);
        end
    end

    // way touched this cycle, a fill wins over a read
    always_comb begin
        if (memWen) begin
            touchWays = victimWays;
        end else if (ren) begin
            touchWays = hitWays;
        end else begin
            touchWays = '0;
        end
    end

    // set the touched bit, restart the round if all bits would be one
    always_comb begin
        statusNext = statusBits[index] | touchWays;
        if (&statusNext) begin
            statusNext = touchWays;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < icachePkg::SETS; s++) begin
                validBits[s]  <= '0;
                statusBits[s] <= '0;
            end
        end else begin
            if (memWen) begin
                validBits[index] <= validBits[index] | victimWays;
            end
            // a read miss touches nothing
            if (|touchWays) begin
                statusBits[index] <= statusNext;
            end
        end
    end

    // block fill into the victim way
    always_ff @(posedge clk) begin
        if (memWen) begin
            for (int w = 0; w < icachePkg::WAYS; w++) begin
                if (victimWays[w]) begin
                    tagMem[index][w]  <= tag;
                    dataMem[index][w] <= dataIn;
                end
            end
        end
    end

    // controller never reads and fills in the same cycle
    assert property (@(posedge clk) disable iff (!rst) !(ren && memWen))
        else $error("icacheArray: ren and memWen high together");

endmodule

`default_nettype wire

// File: icache/icacheCtrl.sv
/*
 * Instruction fetch controller.
 * Looks up each fetch in the cache, delivers hits one cycle later and
 * walks a miss through refill and a retry lookup.
 */
`timescale 1ns/1ps
`default_nettype none

module icacheCtrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              req,
    input  memPkg::addrT      addr,
    input  logic              arrHit,
    input  memPkg::blockT     arrData,
    input  logic              memValid,
    output memPkg::wordT      instr,
    output logic              valid,
    output logic              wasHit,
    output logic              busy,
    output logic              arrRen,
    output logic              arrWen,
    output memPkg::blockAddrT arrBlockAddr,
    output logic              memReq,
    output memPkg::blockAddrT memBlockAddr
);

    typedef enum logic [1:0] {
        stIdle,
        stWait,
        stFill,
        stRetry
    } stateT;

    stateT              state;
    stateT              stateNext;

    // miss context, held until the retry delivers
    memPkg::blockAddrT  missBlock;
    icachePkg::offsetT  missOffset;

    memPkg::blockAddrT  reqBlock;
    icachePkg::offsetT  reqOffset;
    icachePkg::offsetT  wordSel;
    logic               newLookup;
    logic               newMiss;
    logic               deliver;

    // skip the two byte bits
    assign reqOffset = addr[2 +: icachePkg::OFFSET_BITS];
    assign reqBlock  = addr[memPkg::ADDR_BITS-1 -: memPkg::BLOCK_ADDR_BITS];

    assign newLookup = (state == stIdle) && req;
    assign newMiss   = newLookup && !arrHit;
    // word goes out next cycle on a fresh hit or on the retry
    assign deliver   = (newLookup && arrHit) || (state == stRetry);

    assign arrRen       = newLookup || (state == stRetry);
    assign arrWen       = (state == stFill) && memValid;
    assign arrBlockAddr = (state == stIdle) ? reqBlock : missBlock;
    assign wordSel      = (state == stIdle) ? reqOffset : missOffset;

    assign memReq       = (state == stWait);
    assign memBlockAddr = missBlock;
    assign busy         = (state != stIdle);

    always_comb begin
        stateNext = state;
        case (state)
            stIdle:  if (newMiss) stateNext = stWait;
            // request goes out for one cycle
            stWait:  stateNext = stFill;
            stFill:  if (memValid) stateNext = stRetry;
            stRetry: stateNext = stIdle;
            default: stateNext = stIdle;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state  <= stIdle;
            valid  <= 1'b0;
            wasHit <= 1'b0;
        end else begin
            state  <= stateNext;
            valid  <= deliver;
            wasHit <= deliver && (state == stIdle);
        end
    end

    always_ff @(posedge clk) begin
        if (newMiss) begin
            missBlock  <= reqBlock;
            missOffset <= reqOffset;
        end
        if (deliver) begin
            instr <= arrData[wordSel*memPkg::WORD_BITS +: memPkg::WORD_BITS];
        end
    end

    // a miss stays silent until its single delivery
    assert property (@(posedge clk) disable iff (!rst)
        newMiss |=> !valid [*(memPkg::MEM_LATENCY+2)] ##1 (valid && !wasHit))
        else $error("icacheCtrl: bad valid sequence across a miss");

    // the refilled block must be found again
    assert property (@(posedge clk) disable iff (!rst) (state == stRetry) |-> arrHit)
        else $error("icacheCtrl: retry lookup missed");

endmodule

`default_nettype wire

// File: hw/instrMem.sv
/*
 * Instruction memory.
 * Word-wide load port for filling from outside, block-wide read that
 * answers a request after a fixed latency.
 */
`timescale 1ns/1ps
`default_nettype none

module instrMem (
    input  logic              clk,
    input  logic              rst,
    input  logic              loadEn,
    input  memPkg::wordAddrT  loadAddr,
    input  memPkg::wordT      loadData,
    input  logic              memReq,
    input  memPkg::blockAddrT memBlockAddr,
    output logic              memValid,
    output memPkg::blockT     memData
);

    memPkg::wordT      words [2**$bits(memPkg::wordAddrT)];

    memPkg::blockAddrT reqBlock;
    memPkg::latCntT    waitCnt;
    logic              pending;
    logic              readDone;
    memPkg::blockT     readBlock;

    always_ff @(posedge clk) begin
        if (loadEn) begin
            words[loadAddr] <= loadData;
        end
    end

    // gather the block, word 0 in the low bits
    always_comb begin
        for (int k = 0; k < memPkg::BLOCK_WORDS; k++) begin
            readBlock[k*memPkg::WORD_BITS +: memPkg::WORD_BITS] = words[{reqBlock, 2'(k)}];
        end
    end

    assign readDone = pending && (waitCnt == memPkg::latCntT'(1));

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pending  <= 1'b0;
            waitCnt  <= '0;
            memValid <= 1'b0;
        end else begin
            memValid <= readDone;
            if (memReq) begin
                pending <= 1'b1;
                waitCnt <= memPkg::latCntT'(memPkg::MEM_LATENCY - 1);
            end else if (pending) begin
                pending <= !readDone;
                waitCnt <= waitCnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (memReq) begin
            reqBlock <= memBlockAddr;
        end
        if (readDone) begin
            memData <= readBlock;
        end
    end

    // one outstanding read at a time
    assert property (@(posedge clk) disable iff (!rst) memReq |-> !pending)
        else $error("instrMem: memReq while a read is pending");

endmodule

`default_nettype wire

// File: hw/fetchTop.sv
/*
 * Instruction fetch subsystem top.
 * Connects the fetch controller, the cache array and the instruction
 * memory with its load port.
 */
`timescale 1ns/1ps
`default_nettype none

module fetchTop (
    input  logic             clk,
    input  logic             rst,
    input  logic             req,
    input  memPkg::addrT     addr,
    output memPkg::wordT     instr,
    output logic             valid,
    output logic             wasHit,
    output logic             busy,
    input  logic             loadEn,
    input  memPkg::wordAddrT loadAddr,
    input  memPkg::wordT     loadData
);

    logic              arrRen;
    logic              arrWen;
    logic              arrHit;
    memPkg::blockAddrT arrBlockAddr;
    memPkg::blockT     arrData;

    logic              memReq;
    logic              memValid;
    memPkg::blockAddrT memBlockAddr;
    // refill block feeds the array directly
    memPkg::blockT     memData;

    icacheCtrl ctrl0 (
        .clk(clk), .rst(rst), .req(req), .addr(addr),
        .arrHit(arrHit), .arrData(arrData), .memValid(memValid),
        .instr(instr), .valid(valid), .wasHit(wasHit), .busy(busy),
        .arrRen(arrRen), .arrWen(arrWen), .arrBlockAddr(arrBlockAddr),
        .memReq(memReq), .memBlockAddr(memBlockAddr)
    );

    icacheArray array0 (
        .clk(clk), .rst(rst), .ren(arrRen), .memWen(arrWen),
        .blockAddr(arrBlockAddr), .dataIn(memData),
        .hit(arrHit), .dataOut(arrData)
    );

    instrMem mem0 (
        .clk(clk), .rst(rst), .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
        .memReq(memReq), .memBlockAddr(memBlockAddr),
        .memValid(memValid), .memData(memData)
    );

endmodule

`default_nettype wire

// File: tb/fetchTb.sv
/*
 * Testbench for the instruction fetch subsystem.
 * Loads a pseudo-random memory image and runs directed and random fetches.
 * A cache model predicts hits, and concurrent assertions check the words,
 * wasHit, busy and the hit and miss timing.
 */
`timescale 1ns/1ps
`default_nettype none

module fetchTb;

    localparam int LOAD_WORDS      = 1024;
    localparam int RANDOM_FETCHES  = 200;
    // directed plus random fetches, rounded up
    localparam int FETCH_COUNT     = 260;
    localparam int WATCHDOG_CYCLES = FETCH_COUNT * 10 + LOAD_WORDS + 20;

    logic             clk;
    logic             rst;
    logic             req;
    memPkg::addrT     addr;
    memPkg::wordT     instr;
    logic             valid;
    logic             wasHit;
    logic             busy;
    logic             loadEn;
    memPkg::wordAddrT loadAddr;
    memPkg::wordT     loadData;

    // prediction for the fetch on req, used by the timing checks
    logic             reqExpHit;

    memPkg::wordT     image [LOAD_WORDS];
    logic [31:0]      lfsrState = 32'h89ca;
    int               errCount = 0;

    // expected deliveries in fetch order
    memPkg::wordT     expInstrArr [512];
    logic             expHitArr   [512];
    logic [8:0]       issued = '0;
    logic [8:0]       delivIdx = '0;
    memPkg::wordT     headInstr;
    logic             headHit;

    // cache model: valid, MRU and tag per set and way
    icachePkg::wayMaskT mValid  [icachePkg::SETS];
    icachePkg::wayMaskT mStatus [icachePkg::SETS];
    icachePkg::tagT     mTag    [icachePkg::SETS][icachePkg::WAYS];

    fetchTop dut0 (
        .clk(clk), .rst(rst), .req(req), .addr(addr),
        .instr(instr), .valid(valid), .wasHit(wasHit), .busy(busy),
        .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic nextLfsrBit();
        logic fb;
        fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], nextLfsrBit()};
        end
        return r;
    endfunction

    function automatic memPkg::addrT makeAddr(input icachePkg::tagT t,
                                              input icachePkg::indexT s,
                                              input icachePkg::offsetT o);
        return {t, s, o, 2'b00};
    endfunction

    // applies lookup, victim and MRU rules, returns the predicted hit
    function automatic logic modelAccess(input memPkg::blockAddrT b);
        icachePkg::indexT idx;
        icachePkg::tagT   tg;
        int               way;
        logic             hit;
        idx = b[2:0];
        tg  = b[7:3];
        way = -1;
        for (int w = 0; w < icachePkg::WAYS; w++) begin
            if (mValid[idx][w] && mTag[idx][w] == tg) way = w;
        end
        hit = (way >= 0);
        if (!hit) begin
            // walk downwards so the lowest candidate is kept
            for (int w = icachePkg::WAYS - 1; w >= 0; w--) begin
                if (&mValid[idx]) begin
                    if (!mStatus[idx][w]) way = w;
                end else if (!mValid[idx][w]) begin
                    way = w;
                end
            end
            mValid[idx][way] = 1'b1;
            mTag[idx][way]   = tg;
        end
        mStatus[idx][way] = 1'b1;
        if (&mStatus[idx]) mStatus[idx] = icachePkg::wayMaskT'(1) << way;
        return hit;
    endfunction

    task automatic fetchWord(input memPkg::addrT a);
        logic expHit;
        while (busy) begin
            @(posedge clk);
            #1;
        end
        expHit = modelAccess(a[11:4]);
        expInstrArr[issued] = image[a[11:2]];
        expHitArr[issued]   = expHit;
        issued    = issued + 1'b1;
        req       = 1'b1;
        addr      = a;
        reqExpHit = expHit;
        @(posedge clk);
        #1;
        req       = 1'b0;
        reqExpHit = 1'b0;
    endtask

    task automatic loadImage();
        for (int i = 0; i < LOAD_WORDS; i++) begin
            loadEn   = 1'b1;
            loadAddr = memPkg::wordAddrT'(i);
            loadData = image[i];
            @(posedge clk);
            #1;
        end
        loadEn = 1'b0;
    endtask

    assign headInstr = expInstrArr[delivIdx];
    assign headHit   = expHitArr[delivIdx];

    always @(posedge clk) begin
        if (rst && valid) delivIdx <= delivIdx + 1'b1;
    end

    aReset: assert property (@(posedge clk) $rose(rst) |-> (!valid && !busy && !wasHit))
        else begin
            errCount++;
            $display("valid, busy or wasHit not low after reset at %0t", $time);
        end

    aInstr: assert property (@(posedge clk) disable iff (!rst) valid |-> instr == headInstr)
        else begin
            errCount++;
            $display("** Error at %0t: instr expected %h, got %h",
                     $time, $sampled(headInstr), $sampled(instr));
        end

    aWasHit: assert property (@(posedge clk) disable iff (!rst) valid |-> wasHit == headHit)
        else begin
            errCount++;
            $display("** Error at %0t: wasHit expected %b, got %b",
                     $time, $sampled(headHit), $sampled(wasHit));
        end

    aBusyLow: assert property (@(posedge clk) disable iff (!rst) valid |-> !busy)
        else begin
            errCount++;
            $display("** Error at %0t: busy expected 0, got 1", $time);
        end

    aNoExtra: assert property (@(posedge clk) disable iff (!rst) valid |-> delivIdx < issued)
        else begin
            errCount++;
            $display("valid rose with no fetch outstanding at %0t", $time);
        end

    aHitTiming: assert property (@(posedge clk) disable iff (!rst)
        (req && reqExpHit) |=> valid)
        else begin
            errCount++;
            $display("hit did not deliver one cycle after req at %0t", $time);
        end

    // busy through cycle 6, delivery in cycle 7
    aMissTiming: assert property (@(posedge clk) disable iff (!rst)
        (req && !reqExpHit) |=> (busy && !valid) [*(memPkg::MEM_LATENCY+2)] ##1 (valid && !busy))
        else begin
            errCount++;
            $display("miss did not hold busy and deliver in cycle 7 at %0t", $time);
        end

    initial begin
        #(WATCHDOG_CYCLES * 10);
        errCount++;
        $display("watchdog expired with %0d of %0d fetches delivered", delivIdx, issued);
        $display("errors: %0d", errCount);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst       = 1'b0;
        req       = 1'b0;
        addr      = '0;
        loadEn    = 1'b0;
        loadAddr  = '0;
        loadData  = '0;
        reqExpHit = 1'b0;
        for (int s = 0; s < icachePkg::SETS; s++) begin
            mValid[s]  = '0;
            mStatus[s] = '0;
        end
        for (int i = 0; i < LOAD_WORDS; i++) image[i] = randBits(32);
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b1;
        loadImage();

        // cold miss, then every offset of the block back to back
        fetchWord(makeAddr(5'd1, 3'd0, 2'd2));
        for (int k = 0; k < 4; k++) fetchWord(makeAddr(5'd1, 3'd0, icachePkg::offsetT'(k)));
        fetchWord(makeAddr(5'd2, 3'd1, 2'd3));
        for (int k = 3; k >= 0; k--) fetchWord(makeAddr(5'd2, 3'd1, icachePkg::offsetT'(k)));

        // five tags into set 3, then retained tags and the evicted one
        for (int t = 0; t < 5; t++) fetchWord(makeAddr(icachePkg::tagT'(t), 3'd3, 2'd1));
        for (int t = 1; t < 4; t++) fetchWord(makeAddr(icachePkg::tagT'(t), 3'd3, 2'd0));
        fetchWord(makeAddr(5'd0, 3'd3, 2'd3));

        // hits reorder MRU in set 5 and wrap it on way 0 before the next fills
        for (int t = 10; t < 14; t++) fetchWord(makeAddr(icachePkg::tagT'(t), 3'd5, 2'd0));
        fetchWord(makeAddr(5'd11, 3'd5, 2'd1));
        fetchWord(makeAddr(5'd12, 3'd5, 2'd2));
        fetchWord(makeAddr(5'd10, 3'd5, 2'd3));
        fetchWord(makeAddr(5'd14, 3'd5, 2'd0));
        fetchWord(makeAddr(5'd12, 3'd5, 2'd0));
        fetchWord(makeAddr(5'd10, 3'd5, 2'd0));
        fetchWord(makeAddr(5'd15, 3'd5, 2'd1));
        fetchWord(makeAddr(5'd13, 3'd5, 2'd2));

        for (int n = 0; n < RANDOM_FETCHES; n++) fetchWord(memPkg::addrT'(randBits(12)));

        while (delivIdx != issued) begin
            @(posedge clk);
            #1;
        end
        repeat (2) @(posedge clk);
        $display("errors: %0d, fetches: %0d", errCount, issued);
        if (errCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
common/memPkg.sv
common/icachePkg.sv
icache/icacheArray.sv
icache/icacheCtrl.sv
hw/instrMem.sv
hw/fetchTop.sv
tb/fetchTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the fetch subsystem testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module fetchTb \
    -Mdir obj_dir \
    -o fetchSim

output=$(./obj_dir/fetchSim)
echo "$output"

if grep -qx "TEST PASSED" <<< "$output"; then
    exit 0
else
    exit 1
fi
